//--- bench/wb_testdata.txt
# name rf_we waddr wdata pc read_tid csr_re csr_we csr_num wmask wvalue ertn excep esubcode vaddr
# kind expected; all hex, excep bits msb first are int adef syscall brk ine ale
wr_r5 1 05 a5a50001 1c000000 0 0 0 000 0 0 0 00 000 0 wdata a5a50001
wr_r0 1 00 deadbeef 1c000004 0 0 0 000 0 0 0 00 000 0 wdata deadbeef
set_save1 0 00 0 1c000008 0 0 1 031 ffffffff 12345678 0 00 000 0 none 0
mask_save1 0 00 0 1c00000c 0 0 1 031 0000ffff 9999abcd 0 00 000 0 none 0
rd_save1 1 06 0 1c000010 0 1 0 031 0 0 0 00 000 0 wdata 1234abcd
rdcntid 1 07 0 1c000014 1 0 0 000 0 0 0 00 000 0 wdata 00001234
set_eentry 0 00 0 1c000018 0 0 1 00c ffffffff 1c000100 0 00 000 0 none 0
set_crmd 0 00 0 1c00001c 0 0 1 000 00000007 00000007 0 00 000 0 none 0
ex_sys 1 05 33333333 1c000020 0 0 0 000 0 0 0 0c 000 0 flush 1c000100
kill_sys 1 05 22222222 1c000024 0 0 0 000 0 0 0 00 000 0 kill a5a50001
rd_estat_sys 1 09 0 1c000100 0 1 0 005 0 0 0 00 000 0 ecode 0000000b
rd_era 1 09 0 1c000104 0 1 0 006 0 0 0 00 000 0 wdata 1c000020
rd_prmd 1 09 0 1c000108 0 1 0 001 0 0 0 00 000 0 wdata 00000007
ex_ale 1 0a 44444444 1c00010c 0 0 0 000 0 0 0 01 000 1c0003f3 flush 1c000100
rd_badv 1 0a 0 1c000100 0 1 0 007 0 0 0 00 000 0 wdata 1c0003f3
rd_estat_ale 1 0a 0 1c000104 0 1 0 005 0 0 0 00 000 0 ecode 00000009
ex_prio 0 00 0 1c000108 0 0 0 000 0 0 0 15 000 00000abc flush 1c000100
rd_estat_prio 1 0b 0 1c000100 0 1 0 005 0 0 0 00 000 0 ecode 00000008
ex_int 0 00 0 1c00010c 0 0 0 000 0 0 0 22 000 0 flush 1c000100
rd_estat_int 1 0b 0 1c000100 0 1 0 005 0 0 0 00 000 0 ecode 00000000
set_prmd 0 00 0 1c000104 0 0 1 001 00000007 00000005 0 00 000 0 none 0
set_era 0 00 0 1c000108 0 0 1 006 ffffffff 1c000200 0 00 000 0 none 0
do_ertn 0 00 0 1c000300 0 0 0 000 0 0 1 00 000 0 flush 1c000200
kill_ertn 1 06 55555555 1c000304 0 0 0 000 0 0 0 00 000 0 kill 1234abcd
rd_crmd 1 0b 0 1c000200 0 1 0 000 0 0 0 00 000 0 wdata 0000000d

//--- files.f
+incdir+common
common/wb_pkg.sv
hdl/reg_file.sv
csr/csr_file.sv
wb/wb_stage.sv
hdl/wb_top.sv
bench/tb_wb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the writeback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_wb_top -o sim_tb_wb_top
./obj_dir/sim_tb_wb_top > sim.log 2>&1
cat sim.log

# pass only if the testbench reported success
grep -q "ALL CHECKS PASSED" sim.log

//--- bench/tb_wb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wb_top;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 mem_to_wb_valid;
    wb_pkg::mem_to_wb_t   mem_to_wb_bus;
    logic                 wb_allowin;
    wb_pkg::reg_addr_t    rf_raddr1;
    wb_pkg::reg_addr_t    rf_raddr2;
    wb_pkg::word_t        rf_rdata1;
    wb_pkg::word_t        rf_rdata2;
    wb_pkg::wb_to_id_t    wb_to_id;
    wb_pkg::wb_to_ex_t    wb_to_ex;
    wb_pkg::word_t        debug_wb_pc;
    logic [3:0]           debug_wb_rf_we;
    wb_pkg::reg_addr_t    debug_wb_rf_wnum;
    wb_pkg::word_t        debug_wb_rf_wdata;
    logic                 flush_valid;
    wb_pkg::word_t        flush_pc;

    wb_pkg::mem_to_wb_t   recs[$];
    string                names[$];
    string                kinds[$];
    wb_pkg::word_t        expects[$];
    string                cur_name;
    int                   seed = 35;
    int                   tests = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   test_errors = 0;
    int                   cycles = 0;
    int                   max_cycles = 1000;

    wb_top wb_top_i (
        .clk               (clk),
        .resetn            (resetn),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_to_wb_bus     (mem_to_wb_bus),
        .wb_allowin        (wb_allowin),
        .rf_raddr1         (rf_raddr1),
        .rf_raddr2         (rf_raddr2),
        .rf_rdata1         (rf_rdata1),
        .rf_rdata2         (rf_rdata2),
        .wb_to_id          (wb_to_id),
        .wb_to_ex          (wb_to_ex),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .flush_valid       (flush_valid),
        .flush_pc          (flush_pc)
    );

    always #10 clk = ~clk;    // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string what, input wb_pkg::word_t exp,
                              input wb_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            note_error();
            $display("[FAIL] %s %s: expected %08h, actual %08h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_ecode(input string what, input wb_pkg::ecode_t exp,
                               input wb_pkg::ecode_t act);
        checks++;
        if (act !== exp) begin
            note_error();
            $display("[FAIL] %s %s: expected %02h, actual %02h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input wb_pkg::reg_addr_t exp,
                              input wb_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            note_error();
            $display("[FAIL] %s %s: expected r%0d, actual r%0d", cur_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input bit exp, input logic act);
        checks++;
        if (act !== exp) begin
            note_error();
            $display("[FAIL] %s %s: expected %0b, actual %0b", cur_name, what, exp, act);
        end
    endtask

    task automatic load_records(output bit ok);
        int                 fd;
        int                 n;
        string              line;
        string              tname;
        string              tkind;
        logic [31:0]        v [15];
        wb_pkg::mem_to_wb_t rec;
        ok = 1'b1;
        fd = $fopen("bench/wb_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/wb_testdata.txt");
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %h",
                                tname, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                v[8], v[9], v[10], v[11], v[12], v[13], tkind, v[14]);
                    if (n != 17) begin
                        $display("malformed testdata line: %s", line);
                        ok = 1'b0;
                    end else begin
                        rec            = '0;
                        rec.rf_we      = v[0][0];
                        rec.rf_waddr   = v[1][4:0];
                        rec.rf_wdata   = v[2];
                        rec.pc         = v[3];
                        rec.read_tid   = v[4][0];
                        rec.csr_re     = v[5][0];
                        rec.csr_we     = v[6][0];
                        rec.csr_num    = v[7][13:0];
                        rec.csr_wmask  = v[8];
                        rec.csr_wvalue = v[9];
                        rec.ertn       = v[10][0];
                        rec.excep      = v[11][5:0];
                        rec.esubcode   = v[12][8:0];
                        rec.vaddr      = v[13];
                        recs.push_back(rec);
                        names.push_back(tname);
                        kinds.push_back(tkind);
                        expects.push_back(v[14]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // outputs during the record's WB cycle
    task automatic check_wb_cycle(input int idx);
        wb_pkg::mem_to_wb_t rec;
        wb_pkg::word_t      exp;
        rec = recs[idx];
        exp = expects[idx];
        check_flag("allowin", 1'b1, wb_allowin);      // no back-pressure ever
        if (kinds[idx] == "wdata") begin
            check_flag("flush valid", 1'b0, flush_valid);
            check_flag("trace we", rec.rf_we, |debug_wb_rf_we);
            check_word("trace pc", rec.pc, debug_wb_pc);
            check_addr("trace wnum", rec.rf_waddr, debug_wb_rf_wnum);
            check_word("trace wdata", exp, debug_wb_rf_wdata);
            check_flag("fwd we", rec.rf_we, wb_to_id.we);
            check_addr("fwd waddr", rec.rf_waddr, wb_to_id.waddr);
            check_word("fwd wdata", exp, wb_to_id.wdata);
        end else if (kinds[idx] == "ecode") begin
            check_ecode("estat ecode", exp[5:0], debug_wb_rf_wdata[21:16]);
        end else if (kinds[idx] == "flush") begin
            check_flag("flush valid", 1'b1, flush_valid);
            check_word("flush pc", exp, flush_pc);
            check_flag("trace we", 1'b0, |debug_wb_rf_we);
            check_flag("fwd we", 1'b0, wb_to_id.we);
            check_flag("ex hint", rec.excep != '0, wb_to_ex.ex_in_wb);
            check_flag("ertn hint", rec.ertn, wb_to_ex.ertn_in_wb);
        end else if (kinds[idx] == "kill") begin
            check_flag("flush valid", 1'b0, flush_valid);
            check_flag("trace we", 1'b0, |debug_wb_rf_we);
            check_flag("fwd we", 1'b0, wb_to_id.we);
            check_flag("ex hint", 1'b0, wb_to_ex.ex_in_wb);
            check_flag("ertn hint", 1'b0, wb_to_ex.ertn_in_wb);
        end else if (kinds[idx] != "none") begin
            $display("%s uses an unknown check kind %s", cur_name, kinds[idx]);
            note_error();
        end
    endtask

    // register file contents one cycle after writeback
    task automatic check_after_commit(input int idx);
        wb_pkg::mem_to_wb_t rec;
        wb_pkg::word_t      rd_exp;
        rec    = recs[idx];
        rd_exp = expects[idx];
        if (rec.rf_waddr == 5'd0) begin
            rd_exp = '0;      // r0 stays zero
        end
        if (kinds[idx] == "wdata" && rec.rf_we) begin
            check_word("rf read", rd_exp, rf_rdata1);
            check_word("rf read port 2", rd_exp, rf_rdata2);
        end else if (kinds[idx] == "kill") begin
            check_word("rf unchanged", rd_exp, rf_rdata1);
            check_word("rf unchanged port 2", rd_exp, rf_rdata2);
        end
    endtask

    task automatic run_record(input int idx);
        wb_pkg::mem_to_wb_t rec;
        int                 gap;
        rec         = recs[idx];
        cur_name    = names[idx];
        test_errors = 0;
        // a kill record was already put on the bus by the flushing record
        if (kinds[idx] != "kill") begin
            gap = $random(seed) & 1;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            mem_to_wb_valid <= 1'b1;
            mem_to_wb_bus   <= rec;
            rf_raddr1       <= rec.rf_waddr;
            rf_raddr2       <= rec.rf_waddr;
            @(posedge clk);                       // record now in WB
            if (idx + 1 < recs.size() && kinds[idx + 1] == "kill") begin
                mem_to_wb_bus <= recs[idx + 1];   // lands on the flush edge
                rf_raddr1     <= recs[idx + 1].rf_waddr;
                rf_raddr2     <= recs[idx + 1].rf_waddr;
            end else begin
                mem_to_wb_valid <= 1'b0;
            end
            @(negedge clk);
        end
        check_wb_cycle(idx);
        @(posedge clk);                           // commit edge
        mem_to_wb_valid <= 1'b0;
        @(negedge clk);
        check_after_commit(idx);
        if (test_errors == 0) begin
            $display("[PASS] %s", cur_name);
        end else begin
            $display("[DONE] %s with %0d errors", cur_name, test_errors);
        end
    endtask

    initial begin
        bit ok;
        resetn          <= 1'b0;
        mem_to_wb_valid <= 1'b0;
        mem_to_wb_bus   <= '0;
        rf_raddr1       <= '0;
        rf_raddr2       <= '0;
        load_records(ok);
        max_cycles = recs.size() * 4 + 50;
        if (!ok) begin
            $display("testdata could not be loaded");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            resetn <= 1'b1;
            for (int i = 0; i < recs.size(); i++) begin
                run_record(i);
                tests++;
            end
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hdl/wb_top.sv
`timescale 1ns/1ns
`default_nettype none

module wb_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     mem_to_wb_valid,
    input  wire wb_pkg::mem_to_wb_t mem_to_wb_bus,
    output logic                    wb_allowin,
    input  wire wb_pkg::reg_addr_t  rf_raddr1,
    input  wire wb_pkg::reg_addr_t  rf_raddr2,
    output wb_pkg::word_t           rf_rdata1,
    output wb_pkg::word_t           rf_rdata2,
    output wb_pkg::wb_to_id_t       wb_to_id,
    output wb_pkg::wb_to_ex_t       wb_to_ex,
    output wb_pkg::word_t           debug_wb_pc,
    output logic [3:0]              debug_wb_rf_we,
    output wb_pkg::reg_addr_t       debug_wb_rf_wnum,
    output wb_pkg::word_t           debug_wb_rf_wdata,
    output logic                    flush_valid,
    output wb_pkg::word_t           flush_pc
);

    wb_pkg::csr_req_t  csr_req;
    wb_pkg::word_t     csr_rvalue;
    wb_pkg::ex_info_t  ex_info;
    logic              ertn_flush;
    wb_pkg::word_t     ex_entry;
    wb_pkg::word_t     era_pc;
    logic              rf_we;
    wb_pkg::reg_addr_t rf_waddr;
    wb_pkg::word_t     rf_wdata;

    wb_stage wb_stage_i (
        .clk               (clk),
        .resetn            (resetn),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_to_wb_bus     (mem_to_wb_bus),
        .wb_allowin        (wb_allowin),
        .csr_req           (csr_req),
        .csr_rvalue        (csr_rvalue),
        .ex_info           (ex_info),
        .ertn_flush        (ertn_flush),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .wb_to_id          (wb_to_id),
        .wb_to_ex          (wb_to_ex),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file csr_file_i (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .csr_rvalue (csr_rvalue),
        .ex_info    (ex_info),
        .ertn_flush (ertn_flush),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // redirect target, exception entry wins over ertn
    assign flush_valid = ex_info.ex | ertn_flush;
    assign flush_pc    = ex_info.ex ? ex_entry : era_pc;

endmodule

`default_nettype wire

//--- wb/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_defs.svh"

module wb_stage (
    input  wire                     clk,
    input  wire                     resetn,
    // from memory stage
    input  wire                     mem_to_wb_valid,
    input  wire wb_pkg::mem_to_wb_t mem_to_wb_bus,
    output logic                    wb_allowin,
    // csr file
    output wb_pkg::csr_req_t        csr_req,
    input  wire wb_pkg::word_t      csr_rvalue,
    output wb_pkg::ex_info_t        ex_info,
    output logic                    ertn_flush,
    // register file write port
    output logic                    rf_we,
    output wb_pkg::reg_addr_t       rf_waddr,
    output wb_pkg::word_t           rf_wdata,
    // forwarding and flush hints
    output wb_pkg::wb_to_id_t       wb_to_id,
    output wb_pkg::wb_to_ex_t       wb_to_ex,
    // trace compare
    output wb_pkg::word_t           debug_wb_pc,
    output logic [3:0]              debug_wb_rf_we,
    output wb_pkg::reg_addr_t       debug_wb_rf_wnum,
    output wb_pkg::word_t           debug_wb_rf_wdata
);

    logic               wb_valid;
    logic               ready_go;
    wb_pkg::mem_to_wb_t wb_bus;
    logic               excep_any;     // some cause flag set in the held record
    logic               wb_ex;
    logic               flush;
    wb_pkg::ecode_t     ecode;
    wb_pkg::word_t      result;

    assign ready_go   = 1'b1;        // writeback never stalls
    assign wb_allowin = ~wb_valid | ready_go;

    assign excep_any  = |wb_bus.excep;
    assign wb_ex      = wb_valid & excep_any;
    assign ertn_flush = wb_valid & wb_bus.ertn & ~excep_any;
    assign flush      = wb_ex | ertn_flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush) begin
            wb_valid <= 1'b0;        // kills the record arriving on this edge
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_bus <= mem_to_wb_bus;
        end
    end

    // fixed priority ecode
    always_comb begin
        if (wb_bus.excep.intr) begin
            ecode = `ECODE_INT;
        end else if (wb_bus.excep.adef) begin
            ecode = `ECODE_ADEF;
        end else if (wb_bus.excep.syscall) begin
            ecode = `ECODE_SYS;
        end else if (wb_bus.excep.brk) begin
            ecode = `ECODE_BRK;
        end else if (wb_bus.excep.ine) begin
            ecode = `ECODE_INE;
        end else begin
            ecode = `ECODE_ALE;
        end
    end

    assign ex_info.ex       = wb_ex;
    assign ex_info.ecode    = ecode;
    assign ex_info.esubcode = wb_bus.esubcode;
    assign ex_info.pc       = wb_bus.pc;
    assign ex_info.vaddr    = wb_bus.vaddr;

    // rdcntid goes through the csr read path
    assign csr_req.re     = wb_bus.csr_re | wb_bus.read_tid;
    assign csr_req.num    = wb_bus.read_tid ? `CSR_TID : wb_bus.csr_num;
    assign csr_req.we     = wb_valid & wb_bus.csr_we & ~excep_any;
    assign csr_req.wmask  = wb_bus.csr_wmask;
    assign csr_req.wvalue = wb_bus.csr_wvalue;

    assign result = (wb_bus.csr_re || wb_bus.read_tid) ? csr_rvalue : wb_bus.rf_wdata;

    assign rf_we    = wb_valid & wb_bus.rf_we & ~excep_any;
    assign rf_waddr = wb_bus.rf_waddr;
    assign rf_wdata = result;

    assign wb_to_id.we    = rf_we;
    assign wb_to_id.waddr = wb_bus.rf_waddr;
    assign wb_to_id.wdata = result;

    assign wb_to_ex.ex_in_wb   = wb_ex;
    assign wb_to_ex.ertn_in_wb = ertn_flush;

    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_we    = {4{rf_we}};   // byte enables all follow rf_we
    assign debug_wb_rf_wnum  = wb_bus.rf_waddr;
    assign debug_wb_rf_wdata = result;

endmodule

`default_nettype wire

//--- csr/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_defs.svh"

module csr_file (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire wb_pkg::csr_req_t csr_req,
    output wb_pkg::word_t         csr_rvalue,
    input  wire wb_pkg::ex_info_t ex_info,
    input  wire                   ertn_flush,
    output wb_pkg::word_t         ex_entry,
    output wb_pkg::word_t         era_pc
);

    // bits that software may write
    localparam wb_pkg::word_t CRMD_WBITS   = 32'h0000_01ff;
    localparam wb_pkg::word_t PRMD_WBITS   = 32'h0000_0007;
    localparam wb_pkg::word_t ESTAT_WBITS  = 32'h0000_0003;   // only the soft interrupt bits
    localparam wb_pkg::word_t EENTRY_WBITS = 32'hffff_ffc0;

    wb_pkg::word_t crmd;
    wb_pkg::word_t prmd;
    wb_pkg::word_t estat;
    wb_pkg::word_t era;
    wb_pkg::word_t badv;
    wb_pkg::word_t eentry;
    wb_pkg::word_t save [4];
    wb_pkg::word_t tid;
    wb_pkg::word_t rdata;
    logic          vaddr_fault;

    function automatic wb_pkg::word_t merge(input wb_pkg::word_t old_value,
                                            input wb_pkg::word_t bits);
        wb_pkg::word_t mask;
        mask = csr_req.wmask & bits;
        return (old_value & ~mask) | (csr_req.wvalue & mask);
    endfunction

    function automatic logic wr_hit(input wb_pkg::csr_num_t num);
        return csr_req.we && (csr_req.num == num);
    endfunction

    assign vaddr_fault = (ex_info.ecode == `ECODE_ADEF) || (ex_info.ecode == `ECODE_ALE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd  <= `CRMD_RESET;
            prmd  <= '0;
            estat <= '0;
            tid   <= `TID_RESET;
            eentry <= '0;
        end else begin
            if (ex_info.ex) begin
                prmd[2:0]    <= crmd[2:0];          // pie, pplv
                crmd[2:0]    <= 3'b000;             // kernel mode, interrupts off
                estat[21:16] <= ex_info.ecode;
                estat[30:22] <= ex_info.esubcode;
            end else if (ertn_flush) begin
                crmd[2:0] <= prmd[2:0];
            end else begin
                if (wr_hit(`CSR_CRMD))   crmd   <= merge(crmd, CRMD_WBITS);
                if (wr_hit(`CSR_PRMD))   prmd   <= merge(prmd, PRMD_WBITS);
                if (wr_hit(`CSR_ESTAT))  estat  <= merge(estat, ESTAT_WBITS);
                if (wr_hit(`CSR_TID))    tid    <= merge(tid, '1);
                if (wr_hit(`CSR_EENTRY)) eentry <= merge(eentry, EENTRY_WBITS);
            end
        end
    end

    // return state and scratch regs, not reset
    always_ff @(posedge clk) begin
        if (ex_info.ex) begin
            era <= ex_info.pc;
            if (vaddr_fault) begin
                badv <= ex_info.vaddr;
            end
        end else begin
            if (wr_hit(`CSR_ERA))   era     <= merge(era, '1);
            if (wr_hit(`CSR_BADV))  badv    <= merge(badv, '1);
            if (wr_hit(`CSR_SAVE0)) save[0] <= merge(save[0], '1);
            if (wr_hit(`CSR_SAVE1)) save[1] <= merge(save[1], '1);
            if (wr_hit(`CSR_SAVE2)) save[2] <= merge(save[2], '1);
            if (wr_hit(`CSR_SAVE3)) save[3] <= merge(save[3], '1);
        end
    end

    always_comb begin
        case (csr_req.num)
            `CSR_CRMD:   rdata = crmd;
            `CSR_PRMD:   rdata = prmd;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry;
            `CSR_SAVE0:  rdata = save[0];
            `CSR_SAVE1:  rdata = save[1];
            `CSR_SAVE2:  rdata = save[2];
            `CSR_SAVE3:  rdata = save[3];
            `CSR_TID:    rdata = tid;
            default:     rdata = '0;    // unimplemented csr
        endcase
    end

    assign csr_rvalue = csr_req.re ? rdata : '0;
    assign ex_entry   = eentry;
    assign era_pc     = era;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_defs.svh"

module reg_file (
    input  wire                    clk,
    input  wire                    we,
    input  wire wb_pkg::reg_addr_t waddr,
    input  wire wb_pkg::word_t     wdata,
    input  wire wb_pkg::reg_addr_t raddr1,
    input  wire wb_pkg::reg_addr_t raddr2,
    output wb_pkg::word_t          rdata1,
    output wb_pkg::word_t          rdata2
);

    wb_pkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- common/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] word_t;        // data, pc or address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // cause flags, intr is the interrupt flag
    typedef struct packed {
        logic intr;
        logic adef;
        logic syscall;
        logic brk;
        logic ine;
        logic ale;
    } excep_t;

    // memory stage record, qualified by mem_to_wb_valid
    typedef struct packed {
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
        word_t     pc;
        logic      read_tid;     // rdcntid
        logic      csr_re;
        logic      csr_we;
        csr_num_t  csr_num;
        word_t     csr_wmask;
        word_t     csr_wvalue;
        logic      ertn;
        excep_t    excep;
        esubcode_t esubcode;
        word_t     vaddr;
    } mem_to_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_to_id_t;

    typedef struct packed {
        logic ex_in_wb;
        logic ertn_in_wb;
    } wb_to_ex_t;

    typedef struct packed {
        logic     re;
        logic     we;
        csr_num_t num;
        word_t    wmask;
        word_t    wvalue;
    } csr_req_t;

    typedef struct packed {
        logic      ex;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
        word_t     vaddr;
    } ex_info_t;

endpackage

`default_nettype wire

//--- common/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// register file depth
`define REG_COUNT       32

// csr numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040

// exception codes
`define ECODE_INT       6'h00
`define ECODE_ADEF      6'h08
`define ECODE_ALE       6'h09
`define ECODE_SYS       6'h0b
`define ECODE_BRK       6'h0c
`define ECODE_INE       6'h0d

// csr reset values
`define TID_RESET       32'h0000_1234
`define CRMD_RESET      32'h0000_0008   // plv 0, ie 0, da 1

`endif
